/* logic/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] addr_t;   // byte address, 2048 bytes
    typedef logic [7:0]  byte_t;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        LINE_IDLE,
        LINE_START,
        LINE_BITS,
        LINE_STOP
    } line_state_t;

endpackage

`default_nettype wire

/* logic/eeprom_request.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_request (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                wr,
    input  wire                rd,
    input  wire eeprom_pkg::addr_t addr,
    input  wire eeprom_pkg::byte_t wr_data,
    input  wire                busy,
    input  wire                req_taken,
    output logic               req_valid,
    output logic               req_read,
    output eeprom_pkg::addr_t  req_addr,
    output eeprom_pkg::byte_t  req_data
);

    logic capture;

    // only accept when nothing is held and the sequencer is idle
    assign capture = !req_valid && !busy && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
            req_valid <= 1'b0;
        else if (req_taken)
            req_valid <= 1'b0;
        else if (capture)
            req_valid <= 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            req_read <= !wr;        // write wins over read
            req_addr <= addr;
            req_data <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* logic/eeprom_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_sequencer (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                req_valid,
    input  wire                req_read,
    input  wire eeprom_pkg::addr_t req_addr,
    input  wire eeprom_pkg::byte_t req_data,
    input  wire                line_done,
    input  wire eeprom_pkg::byte_t rx_byte,
    output logic               req_taken,
    output logic               busy,
    output logic               line_start,
    output logic               line_stop,
    output logic               line_write,
    output logic               line_read,
    output eeprom_pkg::byte_t  tx_byte,
    output logic               ack,
    output eeprom_pkg::byte_t  rd_data
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t after_state;
    logic                   cmd_sent;  // command of this state already issued
    logic                   issue;
    eeprom_pkg::byte_t      rx_hold;

    always_comb
    begin
        case (state)
            eeprom_pkg::START:   after_state = eeprom_pkg::CTRL_WR;
            eeprom_pkg::CTRL_WR: after_state = eeprom_pkg::ADDR;
            eeprom_pkg::ADDR:    after_state = req_read ? eeprom_pkg::RESTART
                                                        : eeprom_pkg::DATA_WR;
            eeprom_pkg::DATA_WR: after_state = eeprom_pkg::STOP;
            eeprom_pkg::RESTART: after_state = eeprom_pkg::CTRL_RD;
            eeprom_pkg::CTRL_RD: after_state = eeprom_pkg::DATA_RD;
            eeprom_pkg::DATA_RD: after_state = eeprom_pkg::STOP;
            eeprom_pkg::STOP:    after_state = eeprom_pkg::DONE;
            default:             after_state = eeprom_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::IDLE;
            cmd_sent <= 1'b0;
        end
        else
        begin
            case (state)
                eeprom_pkg::IDLE:
                begin
                    cmd_sent <= 1'b0;
                    if (req_valid)
                        state <= eeprom_pkg::START;
                end
                eeprom_pkg::DONE:
                    state <= eeprom_pkg::IDLE;
                default:
                begin
                    if (line_done)
                    begin
                        cmd_sent <= 1'b0;
                        state    <= after_state;
                    end
                    else if (!cmd_sent)
                        cmd_sent <= 1'b1;
                end
            endcase
        end
    end

    // read byte waits here until the stop has gone out
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::DATA_RD && line_done)
            rx_hold <= rx_byte;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            rd_data <= '0;
        else if (state == eeprom_pkg::STOP && line_done && req_read)
            rd_data <= rx_hold;
    end

    assign issue = (state != eeprom_pkg::IDLE) && (state != eeprom_pkg::DONE) && !cmd_sent;

    assign line_start = issue && (state == eeprom_pkg::START || state == eeprom_pkg::RESTART);
    assign line_stop  = issue && (state == eeprom_pkg::STOP);
    assign line_read  = issue && (state == eeprom_pkg::DATA_RD);
    assign line_write = issue && (state == eeprom_pkg::CTRL_WR || state == eeprom_pkg::ADDR ||
                                  state == eeprom_pkg::DATA_WR || state == eeprom_pkg::CTRL_RD);

    always_comb
    begin
        case (state)
            eeprom_pkg::CTRL_WR: tx_byte = {eeprom_pkg::DEVICE_CODE, req_addr[10:8], 1'b0};
            eeprom_pkg::CTRL_RD: tx_byte = {eeprom_pkg::DEVICE_CODE, req_addr[10:8], 1'b1};
            eeprom_pkg::ADDR:    tx_byte = req_addr[7:0];
            eeprom_pkg::DATA_WR: tx_byte = req_data;
            default:             tx_byte = '0;
        endcase
    end

    assign req_taken = (state == eeprom_pkg::IDLE) && req_valid;
    assign busy      = (state != eeprom_pkg::IDLE);
    assign ack       = (state == eeprom_pkg::DONE);   // one cycle, rd_data valid

endmodule

`default_nettype wire

/* logic/eeprom_serial_line.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_serial_line #(
    parameter int QUARTER_CYCLES = 1
) (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                line_start,
    input  wire                line_stop,
    input  wire                line_write,
    input  wire                line_read,
    input  wire eeprom_pkg::byte_t tx_byte,
    input  wire                sda_in,
    output logic               line_done,
    output eeprom_pkg::byte_t  rx_byte,
    output logic               scl,
    output logic               sda_out,
    output logic               sda_oe
);

    localparam int CNT_W = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(QUARTER_CYCLES - 1);

    eeprom_pkg::line_state_t state;
    logic [CNT_W-1:0]        cnt;
    logic [1:0]              quarter;   // 0,1 scl low; 2,3 scl high
    logic [3:0]              bit_idx;
    logic                    is_read;
    logic                    sda_low;
    logic                    tick;
    logic                    last_bit;
    eeprom_pkg::byte_t       shreg;

    assign tick     = (state != eeprom_pkg::LINE_IDLE) && (cnt == CNT_LAST);
    assign last_bit = (bit_idx == 4'd8);   // ninth clock, ack slot

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::LINE_IDLE;
            cnt       <= '0;
            quarter   <= 2'd0;
            bit_idx   <= 4'd0;
            is_read   <= 1'b0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
            line_done <= 1'b0;
        end
        else
        begin
            line_done <= 1'b0;
            if (state == eeprom_pkg::LINE_IDLE)
            begin
                cnt     <= '0;
                quarter <= 2'd0;
                bit_idx <= 4'd0;
                if (line_start || line_stop || line_write || line_read)
                    scl <= 1'b0;
                if (line_start)
                    state <= eeprom_pkg::LINE_START;
                else if (line_stop)
                    state <= eeprom_pkg::LINE_STOP;
                else if (line_write || line_read)
                begin
                    state   <= eeprom_pkg::LINE_BITS;
                    is_read <= line_read;
                end
            end
            else if (tick)
            begin
                cnt     <= '0;
                quarter <= quarter + 2'd1;
                case (quarter)
                    2'd0:   // middle of scl low
                    begin
                        if (state == eeprom_pkg::LINE_START)
                            sda_low <= 1'b0;
                        else if (state == eeprom_pkg::LINE_STOP)
                            sda_low <= 1'b1;
                        else
                            sda_low <= !is_read && !last_bit && !shreg[7];
                    end
                    2'd1:
                        scl <= 1'b1;
                    2'd2:   // middle of scl high
                    begin
                        if (state == eeprom_pkg::LINE_START)
                            sda_low <= 1'b1;
                        else if (state == eeprom_pkg::LINE_STOP)
                            sda_low <= 1'b0;
                    end
                    default:
                    begin
                        if (state == eeprom_pkg::LINE_BITS && !last_bit)
                        begin
                            bit_idx <= bit_idx + 4'd1;
                            scl     <= 1'b0;
                        end
                        else
                        begin
                            state     <= eeprom_pkg::LINE_IDLE;
                            line_done <= 1'b1;
                        end
                    end
                endcase
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::LINE_IDLE && line_write)
            shreg <= tx_byte;
        else if (state == eeprom_pkg::LINE_BITS && tick && quarter == 2'd2 && !last_bit)
            shreg <= {shreg[6:0], sda_in};   // msb out, sample in
        if (state == eeprom_pkg::LINE_BITS && tick && quarter == 2'd3 && last_bit && is_read)
            rx_byte <= shreg;
    end

    // open drain, only ever pulls low
    assign sda_oe  = sda_low;
    assign sda_out = 1'b0;

endmodule

`default_nettype wire

/* logic/eeprom_access.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_access #(
    parameter int QUARTER_CYCLES = 1
) (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                wr,
    input  wire                rd,
    input  wire eeprom_pkg::addr_t addr,
    input  wire eeprom_pkg::byte_t wr_data,
    input  wire                sda_in,
    output logic               ack,
    output eeprom_pkg::byte_t  rd_data,
    output logic               scl,
    output logic               sda_out,
    output logic               sda_oe
);

    logic              req_valid;
    logic              req_read;
    logic              req_taken;
    logic              busy;
    eeprom_pkg::addr_t req_addr;
    eeprom_pkg::byte_t req_data;
    logic              line_start;
    logic              line_stop;
    logic              line_write;
    logic              line_read;
    logic              line_done;
    eeprom_pkg::byte_t tx_byte;
    eeprom_pkg::byte_t rx_byte;

    eeprom_request u_request (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .busy      (busy),
        .req_taken (req_taken),
        .req_valid (req_valid),
        .req_read  (req_read),
        .req_addr  (req_addr),
        .req_data  (req_data)
    );

    eeprom_sequencer u_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req_read   (req_read),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .line_done  (line_done),
        .rx_byte    (rx_byte),
        .req_taken  (req_taken),
        .busy       (busy),
        .line_start (line_start),
        .line_stop  (line_stop),
        .line_write (line_write),
        .line_read  (line_read),
        .tx_byte    (tx_byte),
        .ack        (ack),
        .rd_data    (rd_data)
    );

    eeprom_serial_line #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) u_serial_line (
        .CLK        (CLK),
        .RESET      (RESET),
        .line_start (line_start),
        .line_stop  (line_stop),
        .line_write (line_write),
        .line_read  (line_read),
        .tx_byte    (tx_byte),
        .sda_in     (sda_in),
        .line_done  (line_done),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

endmodule

`default_nettype wire

/* verification/eeprom_model.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_model (
    input  wire  CLK,
    input  wire  RESET,
    input  wire  scl,
    input  wire  sda,
    output logic sda_pull
);

    eeprom_pkg::byte_t mem [0:2047];
    eeprom_pkg::byte_t shreg;
    eeprom_pkg::byte_t outbuf;
    eeprom_pkg::addr_t ptr;
    logic [2:0]        block;
    logic [1:0]        phase;      // 0 control, 1 address, 2 data
    logic [3:0]        bit_cnt;
    logic              sending;
    logic              send_next;
    logic              prev_scl;
    logic              prev_sda;

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'hff;
            sda_pull  <= 1'b0;
            bit_cnt   <= 4'd0;
            phase     <= 2'd0;
            sending   <= 1'b0;
            send_next <= 1'b0;
            ptr       <= '0;
        end
        else if (scl && prev_scl && (prev_sda != sda))
        begin
            // start or stop, either way back to the control byte
            bit_cnt   <= 4'd0;
            phase     <= 2'd0;
            sending   <= 1'b0;
            send_next <= 1'b0;
            sda_pull  <= 1'b0;
        end
        else if (scl && !prev_scl)
        begin
            if (bit_cnt < 4'd8)
                shreg <= {shreg[6:0], sda};
            bit_cnt <= bit_cnt + 4'd1;
        end
        else if (!scl && prev_scl)
        begin
            if (bit_cnt == 4'd8)
            begin
                if (sending)
                begin
                    sending  <= 1'b0;   // master nacks the only byte
                    sda_pull <= 1'b0;
                end
                else
                begin
                    sda_pull <= 1'b1;
                    case (phase)
                        2'd0:
                        begin
                            if (shreg[7:4] == eeprom_pkg::DEVICE_CODE)
                            begin
                                block     <= shreg[3:1];
                                send_next <= shreg[0];
                                phase     <= 2'd1;
                            end
                            else
                                sda_pull <= 1'b0;
                        end
                        2'd1:
                        begin
                            ptr   <= {block, shreg};
                            phase <= 2'd2;
                        end
                        default:
                        begin
                            mem[ptr] <= shreg;
                            ptr      <= ptr + 11'd1;
                        end
                    endcase
                end
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt  <= 4'd0;
                sda_pull <= 1'b0;
                if (send_next)
                begin
                    send_next <= 1'b0;
                    sending   <= 1'b1;
                    outbuf    <= mem[ptr];
                    sda_pull  <= !mem[ptr][7];
                    ptr       <= ptr + 11'd1;
                end
            end
            else if (sending && bit_cnt != 4'd0)
                sda_pull <= !outbuf[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

`default_nettype wire

/* verification/eeprom_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_checker (
    input  wire                    CLK,
    input  wire                    RESET,
    input  wire                    ack,
    input  wire eeprom_pkg::byte_t rd_data,
    input  wire                    scl,
    input  wire                    sda
);

    int                starts = 0;
    int                stops = 0;
    int                acks = 0;
    int                data_errors = 0;
    int                frame_errors = 0;
    int                base_starts;
    int                base_stops;
    int                base_acks;
    int                test_base;
    int                tests_run = 0;
    int                tests_failed = 0;
    logic              pending = 1'b0;
    logic              exp_read = 1'b0;
    eeprom_pkg::byte_t exp_data;
    string             test_name;
    logic              prev_scl = 1'b1;
    logic              prev_sda = 1'b1;

    always @(posedge CLK)
    begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (!RESET)
        begin
            if (scl && prev_scl && prev_sda && !sda)
            begin
                starts = starts + 1;
                if (!pending)
                begin
                    $display("start condition seen with no request outstanding in %s", test_name);
                    data_errors = data_errors + 1;
                end
            end
            if (scl && prev_scl && !prev_sda && sda)
                stops = stops + 1;
            if (ack)
            begin
                acks = acks + 1;
                if (!pending)
                begin
                    $display("ack pulse with no request outstanding in %s", test_name);
                    data_errors = data_errors + 1;
                end
                else if (exp_read && rd_data !== exp_data)
                begin
                    $display("error %s: read data expected %h actual %h",
                             test_name, exp_data, rd_data);
                    data_errors = data_errors + 1;
                end
            end
        end
    end

    task automatic begin_op(input logic is_read, input eeprom_pkg::byte_t expected);
        exp_read    = is_read;
        exp_data    = expected;
        base_starts = starts;
        base_stops  = stops;
        base_acks   = acks;
        pending     = 1'b1;
    endtask

    task automatic compare_count(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            frame_errors = frame_errors + 1;
        end
    endtask

    // one op is framed by its start(s), a stop and a single ack
    task automatic end_op();
        pending = 1'b0;
        compare_count("ack count", 1, acks - base_acks);
        compare_count("start count", exp_read ? 2 : 1, starts - base_starts);
        compare_count("stop count", 1, stops - base_stops);
    endtask

    task automatic check_idle();
        compare_count("scl", 1, int'(scl === 1'b1));
        compare_count("sda", 1, int'(sda === 1'b1));
        compare_count("ack", 0, int'(ack !== 1'b0));
        compare_count("start count", 0, starts);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = data_errors + frame_errors;
    endtask

    task automatic end_test();
        int n;
        n = data_errors + frame_errors - test_base;
        tests_run = tests_run + 1;
        if (n == 0)
            $display("test %s passed", test_name);
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", test_name, n);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, data_errors + frame_errors);
    endtask

    function automatic logic all_ok();
        return (tests_failed == 0) && (data_errors + frame_errors == 0);
    endfunction

endmodule

`default_nettype wire

/* verification/eeprom_access_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_access_tb;

    localparam int QUARTER_CYCLES = 1;
    localparam int N_OPS = 63;
    localparam int BIT_CYCLES = 4 * QUARTER_CYCLES;
    localparam int CYCLE_LIMIT = N_OPS * BIT_CYCLES * 40 * 2 + 50;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    eeprom_pkg::addr_t addr;
    eeprom_pkg::byte_t wr_data;
    wire               sda_in;
    logic              ack;
    eeprom_pkg::byte_t rd_data;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              model_pull;
    eeprom_pkg::byte_t shadow [0:2047];
    int                seed;
    int                cycles = 0;

    // low if either side pulls
    assign sda_in = !((sda_oe && !sda_out) || model_pull);

    eeprom_access #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_in),
        .ack     (ack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe)
    );

    eeprom_model model0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda_in),
        .sda_pull (model_pull)
    );

    eeprom_checker chk0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .ack     (ack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda     (sda_in)
    );

    function automatic eeprom_pkg::byte_t mem_expect(input eeprom_pkg::addr_t a);
        return shadow[a];   // last byte written or the erased value
    endfunction

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, an ack never came", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic strobe(input logic w, input logic r, input eeprom_pkg::addr_t a,
                          input eeprom_pkg::byte_t d);
        wr      = w;
        rd      = r;
        addr    = a;
        wr_data = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_ack();
        while (ack !== 1'b1)
        begin
            @(posedge CLK);
            #2;
        end
        repeat (4) @(posedge CLK);   // room for a stray second ack
        #2;
    endtask

    task automatic write_op(input eeprom_pkg::addr_t a, input eeprom_pkg::byte_t d);
        chk0.begin_op(1'b0, 8'h00);
        strobe(1'b1, 1'b0, a, d);
        shadow[a] = d;
        wait_ack();
        chk0.end_op();
    endtask

    task automatic read_op(input eeprom_pkg::addr_t a);
        chk0.begin_op(1'b1, mem_expect(a));
        strobe(1'b0, 1'b1, a, 8'h00);
        wait_ack();
        chk0.end_op();
    endtask

    initial
    begin
        logic [31:0]       rnd;
        eeprom_pkg::addr_t last_addr;
        seed      = 32'h4eb3d0fe;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        last_addr = '0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;
        repeat (3) @(posedge CLK);
        #2;
        RESET = 1'b0;

        chk0.start_test("reset_state");
        repeat (10) @(posedge CLK);
        #2;
        chk0.check_idle();
        chk0.end_test();

        chk0.start_test("write_read_back");
        write_op(11'h123, 8'h5a);
        read_op(11'h123);
        read_op(11'h456);   // never written
        chk0.end_test();

        chk0.start_test("random_traffic");
        // same low byte in every block so a lost block bit aliases two of them
        for (int b = 0; b < 8; b++)
            write_op({b[2:0], 8'ha5}, 8'h5a ^ {5'd0, b[2:0]});
        for (int b = 0; b < 8; b++)
            read_op({b[2:0], 8'ha5});
        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            if (rnd[0])
            begin
                write_op(rnd[18:8], rnd[31:24]);
                last_addr = rnd[18:8];
            end
            else if (rnd[1])
                read_op(last_addr);
            else
                read_op(rnd[18:8]);
        end
        chk0.end_test();

        chk0.start_test("wr_rd_together");
        chk0.begin_op(1'b0, 8'h00);
        strobe(1'b1, 1'b1, 11'h2aa, 8'hc3);   // write has priority
        shadow[11'h2aa] = 8'hc3;
        wait_ack();
        chk0.end_op();
        read_op(11'h2aa);
        chk0.end_test();

        chk0.start_test("strobe_while_busy");
        chk0.begin_op(1'b0, 8'h00);
        strobe(1'b1, 1'b0, 11'h531, 8'h96);
        shadow[11'h531] = 8'h96;
        repeat (20) @(posedge CLK);
        #2;
        strobe(1'b1, 1'b0, 11'h1c4, 8'h3e);   // dropped
        wait_ack();
        chk0.end_op();
        read_op(11'h1c4);
        chk0.end_test();

        chk0.report();
        if (chk0.all_ok())
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/eeprom_pkg.sv
logic/eeprom_request.sv
logic/eeprom_sequencer.sv
logic/eeprom_serial_line.sv
logic/eeprom_access.sv
verification/eeprom_model.sv
verification/eeprom_checker.sv
verification/eeprom_access_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = eeprom_access_tb
FILELIST = all.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
